/* files.f */
hdl/axi_wr_pkg.sv
hdl/arb_pkg.sv
hdl/rr_grant.sv
hdl/wr_grant_ctrl.sv
hdl/wr_channel_mux.sv
hdl/bresp_route.sv
hdl/axi_wr_arbiter.sv
testbench/axi_wr_arbiter_tb.sv

/* testbench/axi_wr_arbiter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_arbiter_tb
  import axi_wr_pkg::*;
  import arb_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 400;

  logic clk;
  logic rst_n;
  mgr_mask_t m_awvalid, m_awready, m_wvalid, m_wlast, m_wready, m_bvalid, m_bready;
  id_t    [NUM_M-1:0] m_awid, m_bid;
  addr_t  [NUM_M-1:0] m_awaddr;
  len_t   [NUM_M-1:0] m_awlen;
  size_t  [NUM_M-1:0] m_awsize;
  burst_t [NUM_M-1:0] m_awburst;
  data_t  [NUM_M-1:0] m_wdata;
  strb_t  [NUM_M-1:0] m_wstrb;
  resp_t  [NUM_M-1:0] m_bresp;
  logic s_awvalid, s_awready, s_wvalid, s_wlast, s_wready, s_bvalid, s_bready;
  sid_t s_awid, s_bid;
  addr_t s_awaddr;
  len_t s_awlen;
  size_t s_awsize;
  burst_t s_awburst;
  data_t s_wdata;
  strb_t s_wstrb;
  resp_t s_bresp;

  logic [31:0] lfsr = 32'h2f46_11c6;
  int errors = 0;
  int tests_run = 0;
  int test_start_errs = 0;
  // Subordinate ready mode is 0 random, 1 held low or 2 held high
  int aw_mode = 2;
  int w_mode = 2;
  // Reference model of the open grant and the B stream
  int cur_mgr = -1;
  bit cur_aw = 1'b0;
  bit cur_w = 1'b0;
  int last_mgr = NUM_M - 1;
  bit check_rr = 1'b0;
  int aw_count = 0;
  int wlast_count = 0;
  int b_sent = 0;
  int b_wait = 0;
  int b_stall = 0;
  bit b_fire = 1'b0;
  sid_t b_sid_q[$];
  resp_t b_resp_q[$];

  axi_wr_arbiter UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int onehot_index(input mgr_mask_t mask);
    int idx;
    idx = -1;
    if ($countones(mask) == 1) begin
      for (int i = 0; i < NUM_M; i++)
        if (mask[i])
          idx = i;
    end
    return idx;
  endfunction

  task automatic value_error(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic protocol_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic expire(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Regression failed");
    $finish;
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp)
      value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp)
      value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_sid(input string what, input sid_t got, input sid_t exp);
    if (got !== exp)
      value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_id(input string what, input id_t got, input id_t exp);
    if (got !== exp)
      value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_resp(input string what, input resp_t got, input resp_t exp);
    if (got !== exp)
      value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_mask(input string what, input mgr_mask_t got, input mgr_mask_t exp);
    if (got !== exp)
      value_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
      value_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_ctrl(input len_t gl, input size_t gs, input burst_t gb,
                            input len_t el, input size_t es, input burst_t eb);
    if ({gl, gs, gb} !== {el, es, eb})
      value_error($sformatf("AW len/size/burst got %h/%h/%h expected %h/%h/%h",
                            gl, gs, gb, el, es, eb));
  endtask

  task automatic check_strb(input strb_t gs, input logic gl, input strb_t es, input logic el);
    if ({gs, gl} !== {es, el})
      value_error($sformatf("W strb/last got %h/%b expected %h/%b", gs, gl, es, el));
  endtask

  // A grant belongs to one manager until both AW and wlast are done
  task automatic claim_grant(input int src);
    if (cur_mgr < 0)
      cur_mgr = src;
    else if (cur_mgr != src)
      protocol_error($sformatf("manager %0d handshakes inside grant of %0d", src, cur_mgr));
  endtask

  task automatic run_burst(input int m, input int aw_delay, input int w_delay);
    len_t len;
    int n_aw;
    int n_w;
    len = len_t'(rand_bits(2));
    fork
      begin
        repeat (aw_delay) begin
          @(posedge clk);
          #1;
        end
        m_awid[m] = id_t'(rand_bits(AXI_ID_W));
        m_awaddr[m] = addr_t'(rand_bits(AXI_ADDR_W));
        m_awlen[m] = len;
        m_awsize[m] = 3'd1;
        m_awburst[m] = 2'b01;
        m_awvalid[m] = 1'b1;
        n_aw = 0;
        do begin
          @(negedge clk);
          n_aw++;
          if (n_aw > TIMEOUT_CYCLES)
            expire($sformatf("AW handshake of manager %0d", m));
        end while (!m_awready[m]);
        @(posedge clk);
        #1;
        m_awvalid[m] = 1'b0;
      end
      begin
        repeat (w_delay) begin
          @(posedge clk);
          #1;
        end
        for (int b = 0; b <= int'(len); b++) begin
          m_wdata[m] = data_t'(rand_bits(AXI_DATA_W));
          m_wstrb[m] = strb_t'(rand_bits(AXI_STRB_W));
          m_wlast[m] = (b == int'(len));
          m_wvalid[m] = 1'b1;
          n_w = 0;
          do begin
            @(negedge clk);
            n_w++;
            if (n_w > TIMEOUT_CYCLES)
              expire($sformatf("W handshake of manager %0d", m));
          end while (!m_wready[m]);
          @(posedge clk);
          #1;
        end
        m_wvalid[m] = 1'b0;
        m_wlast[m] = 1'b0;
      end
    join
  endtask

  // Mode 1 lets AW or W start first by a random number of cycles
  task automatic run_manager(input int m, input int count, input int mode);
    int d;
    for (int k = 0; k < count; k++) begin
      d = (mode == 1) ? rand_bits(2) : 0;
      if (rand_bits(1) == 1)
        run_burst(m, d, 0);
      else
        run_burst(m, 0, d);
    end
  endtask

  task automatic run_all(input int count, input int mode);
    fork
      run_manager(0, count, mode);
      run_manager(1, count, mode);
      run_manager(2, count, mode);
    join
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while (b_sent != aw_count || s_bvalid || cur_mgr >= 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT_CYCLES)
        expire("outstanding B responses");
    end
    tests_run++;
    if (errors == test_start_errs)
      $display("Test %0d %s: ok", tests_run, name);
    else
      $display("Test %0d %s: %0d errors", tests_run, name, errors - test_start_errs);
    test_start_errs = errors;
  endtask

  // Subordinate model driven just after each rising edge
  initial begin : subordinate
    s_awready = 1'b0;
    s_wready = 1'b0;
    s_bvalid = 1'b0;
    s_bid = '0;
    s_bresp = '0;
    m_bready = '0;
    forever begin
      @(posedge clk);
      #1;
      s_awready = (aw_mode == 2) || (aw_mode == 0 && rand_bits(1) == 1);
      s_wready = (w_mode == 2) || (w_mode == 0 && rand_bits(1) == 1);
      m_bready = mgr_mask_t'(rand_bits(NUM_M));
      if (b_fire) begin
        b_fire = 1'b0;
        s_bvalid = 1'b0;
        void'(b_sid_q.pop_front());
        void'(b_resp_q.pop_front());
        b_sent++;
        b_wait = rand_bits(2);
      end else if (!s_bvalid && b_sent < wlast_count && b_sid_q.size() > 0) begin
        if (b_wait > 0) begin
          b_wait--;
        end else begin
          s_bvalid = 1'b1;
          s_bid = b_sid_q[0];
          s_bresp = b_resp_q[0];
        end
      end
    end
  end

  // Values at the falling edge are the ones the next rising edge takes
  always @(negedge clk) begin : monitor
    int src;
    sid_t exp_sid;
    mgr_mask_t aw_hs;
    mgr_mask_t w_hs;
    mgr_mask_t own;
    if (rst_n) begin
      aw_hs = m_awvalid & m_awready;
      w_hs = m_wvalid & m_wready;
      if (cur_mgr >= 0) begin
        own = mgr_mask_t'(1) << cur_mgr;
        check_mask("ready outside the open grant", (m_awready | m_wready) & ~own, '0);
      end
      if (s_awvalid && s_awready) begin
        src = onehot_index(aw_hs);
        if (src < 0) begin
          protocol_error("AW handshake without exactly one manager AW handshake");
        end else begin
          exp_sid = {mgr_idx_t'(src), m_awid[src]};
          check_sid("s_awid", s_awid, exp_sid);
          check_addr("s_awaddr", s_awaddr, m_awaddr[src]);
          check_ctrl(s_awlen, s_awsize, s_awburst, m_awlen[src], m_awsize[src], m_awburst[src]);
          if (check_rr && src != (last_mgr + 1) % NUM_M)
            value_error($sformatf("grant order got manager %0d expected %0d",
                                  src, (last_mgr + 1) % NUM_M));
          last_mgr = src;
          claim_grant(src);
          cur_aw = 1'b1;
          b_sid_q.push_back(exp_sid);
          b_resp_q.push_back(resp_t'(rand_bits(2)));
          aw_count++;
        end
      end else if (aw_hs != '0) begin
        protocol_error("manager AW handshake with no subordinate AW handshake");
      end
      if (s_wvalid && s_wready) begin
        src = onehot_index(w_hs);
        if (src < 0) begin
          protocol_error("W handshake without exactly one manager W handshake");
        end else begin
          check_data("s_wdata", s_wdata, m_wdata[src]);
          check_strb(s_wstrb, s_wlast, m_wstrb[src], m_wlast[src]);
          claim_grant(src);
          if (s_wlast) begin
            cur_w = 1'b1;
            wlast_count++;
          end
        end
      end else if (w_hs != '0) begin
        protocol_error("manager W handshake with no subordinate W handshake");
      end
      if (cur_aw && cur_w) begin
        cur_mgr = -1;
        cur_aw = 1'b0;
        cur_w = 1'b0;
      end
      if (s_bvalid) begin
        exp_sid = b_sid_q[0];
        src = int'(exp_sid[S_ID_W-1:AXI_ID_W]);
        check_mask("m_bvalid", m_bvalid, mgr_mask_t'(1) << src);
        check_id("m_bid", m_bid[src], exp_sid[AXI_ID_W-1:0]);
        check_resp("m_bresp", m_bresp[src], b_resp_q[0]);
        check_flag("s_bready", s_bready, m_bready[src]);
        if (s_bready) begin
          b_fire = 1'b1;
          b_stall = 0;
        end else begin
          b_stall++;
          if (b_stall > TIMEOUT_CYCLES)
            expire("B handshake");
        end
      end else begin
        check_mask("m_bvalid", m_bvalid, '0);
      end
    end
  end

  initial begin
    m_awvalid = '0;
    m_awid = '0;
    m_awaddr = '0;
    m_awlen = '0;
    m_awsize = '0;
    m_awburst = '0;
    m_wvalid = '0;
    m_wdata = '0;
    m_wstrb = '0;
    m_wlast = '0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    repeat (4) @(negedge clk);
    check_mask("m_awready", m_awready, '0);
    check_mask("m_wready", m_wready, '0);
    check_mask("m_bvalid", m_bvalid, '0);
    check_flag("s_awvalid", s_awvalid, 1'b0);
    check_flag("s_wvalid", s_wvalid, 1'b0);
    @(posedge clk);
    #1;
    end_test("idle after reset");

    for (int m = 0; m < NUM_M; m++)
      run_manager(m, 1, 0);
    end_test("single burst per manager");

    // AW held off while the first grant's W finishes
    aw_mode = 1;
    fork
      run_manager(0, 1, 0);
      run_manager(1, 1, 0);
      begin
        repeat (20) @(negedge clk);
        aw_mode = 2;
      end
    join
    end_test("AW stalled after W");

    w_mode = 1;
    fork
      run_manager(0, 1, 0);
      run_manager(1, 1, 0);
      begin
        repeat (20) @(negedge clk);
        w_mode = 2;
      end
    join
    end_test("W stalled after AW");

    check_rr = 1'b1;
    aw_mode = 0;
    w_mode = 0;
    run_all(4, 0);
    check_rr = 1'b0;
    end_test("round robin order");

    aw_mode = 2;
    w_mode = 2;
    run_all(3, 1);
    end_test("B routing");

    aw_mode = 0;
    w_mode = 0;
    run_all(20, 1);
    end_test("long random run");

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/axi_wr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_arbiter
  import axi_wr_pkg::*;
  import arb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Manager side
  input  mgr_mask_t            m_awvalid,
  input  id_t    [NUM_M-1:0]   m_awid,
  input  addr_t  [NUM_M-1:0]   m_awaddr,
  input  len_t   [NUM_M-1:0]   m_awlen,
  input  size_t  [NUM_M-1:0]   m_awsize,
  input  burst_t [NUM_M-1:0]   m_awburst,
  output mgr_mask_t            m_awready,

  input  mgr_mask_t            m_wvalid,
  input  data_t  [NUM_M-1:0]   m_wdata,
  input  strb_t  [NUM_M-1:0]   m_wstrb,
  input  mgr_mask_t            m_wlast,
  output mgr_mask_t            m_wready,

  output mgr_mask_t            m_bvalid,
  output id_t    [NUM_M-1:0]   m_bid,
  output resp_t  [NUM_M-1:0]   m_bresp,
  input  mgr_mask_t            m_bready,

  // Subordinate side
  output logic                 s_awvalid,
  output sid_t                 s_awid,
  output addr_t                s_awaddr,
  output len_t                 s_awlen,
  output size_t                s_awsize,
  output burst_t               s_awburst,
  input  logic                 s_awready,

  output logic                 s_wvalid,
  output data_t                s_wdata,
  output strb_t                s_wstrb,
  output logic                 s_wlast,
  input  logic                 s_wready,

  input  logic                 s_bvalid,
  input  sid_t                 s_bid,
  input  resp_t                s_bresp,
  output logic                 s_bready
);

  logic     grant_valid;
  mgr_idx_t grant_idx;
  logic     aw_fire;
  logic     w_last_fire;

  // AW requests drive arbitration directly
  wr_grant_ctrl u_grant_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (m_awvalid),
    .aw_fire    (aw_fire),
    .w_last_fire(w_last_fire),
    .grant_valid(grant_valid),
    .grant_idx  (grant_idx)
  );

  wr_channel_mux u_channel_mux (
    .grant_valid(grant_valid),
    .grant_idx  (grant_idx),
    .m_awvalid  (m_awvalid),
    .m_awid     (m_awid),
    .m_awaddr   (m_awaddr),
    .m_awlen    (m_awlen),
    .m_awsize   (m_awsize),
    .m_awburst  (m_awburst),
    .m_awready  (m_awready),
    .m_wvalid   (m_wvalid),
    .m_wdata    (m_wdata),
    .m_wstrb    (m_wstrb),
    .m_wlast    (m_wlast),
    .m_wready   (m_wready),
    .s_awvalid  (s_awvalid),
    .s_awid     (s_awid),
    .s_awaddr   (s_awaddr),
    .s_awlen    (s_awlen),
    .s_awsize   (s_awsize),
    .s_awburst  (s_awburst),
    .s_awready  (s_awready),
    .s_wvalid   (s_wvalid),
    .s_wdata    (s_wdata),
    .s_wstrb    (s_wstrb),
    .s_wlast    (s_wlast),
    .s_wready   (s_wready),
    .aw_fire    (aw_fire),
    .w_last_fire(w_last_fire)
  );

  // Responses are routed by ID, independent of the current grant
  bresp_route u_bresp_route (
    .s_bvalid(s_bvalid),
    .s_bid   (s_bid),
    .s_bresp (s_bresp),
    .s_bready(s_bready),
    .m_bvalid(m_bvalid),
    .m_bid   (m_bid),
    .m_bresp (m_bresp),
    .m_bready(m_bready)
  );

endmodule

`default_nettype wire

/* hdl/bresp_route.sv */
`timescale 1ns/1ps
`default_nettype none

module bresp_route
  import axi_wr_pkg::*;
  import arb_pkg::*;
(
  input  logic                s_bvalid,
  input  sid_t                s_bid,
  input  resp_t               s_bresp,
  output logic                s_bready,

  output mgr_mask_t           m_bvalid,
  output id_t   [NUM_M-1:0]   m_bid,
  output resp_t [NUM_M-1:0]   m_bresp,
  input  mgr_mask_t           m_bready
);

  mgr_idx_t b_idx;

  // Manager index sits above the original ID
  assign b_idx = s_bid[S_ID_W-1:AXI_ID_W];

  // Unknown index is drained so the subordinate never stalls
  always_comb begin
    m_bvalid = '0;
    s_bready = 1'b1;
    if (int'(b_idx) < NUM_M) begin
      m_bvalid[b_idx] = s_bvalid;
      s_bready        = m_bready[b_idx];
    end
  end

  // Payload fans out to every manager, valid picks the one
  always_comb begin
    for (int i = 0; i < NUM_M; i++) begin
      m_bid[i]   = s_bid[AXI_ID_W-1:0];
      m_bresp[i] = s_bresp;
    end
  end

endmodule

`default_nettype wire

/* hdl/wr_channel_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_channel_mux
  import axi_wr_pkg::*;
  import arb_pkg::*;
(
  // Grant from the control block
  input  logic                 grant_valid,
  input  mgr_idx_t             grant_idx,

  // Manager AW channels
  input  mgr_mask_t            m_awvalid,
  input  id_t    [NUM_M-1:0]   m_awid,
  input  addr_t  [NUM_M-1:0]   m_awaddr,
  input  len_t   [NUM_M-1:0]   m_awlen,
  input  size_t  [NUM_M-1:0]   m_awsize,
  input  burst_t [NUM_M-1:0]   m_awburst,
  output mgr_mask_t            m_awready,

  // Manager W channels
  input  mgr_mask_t            m_wvalid,
  input  data_t  [NUM_M-1:0]   m_wdata,
  input  strb_t  [NUM_M-1:0]   m_wstrb,
  input  mgr_mask_t            m_wlast,
  output mgr_mask_t            m_wready,

  // Subordinate AW channel
  output logic                 s_awvalid,
  output sid_t                 s_awid,
  output addr_t                s_awaddr,
  output len_t                 s_awlen,
  output size_t                s_awsize,
  output burst_t               s_awburst,
  input  logic                 s_awready,

  // Subordinate W channel
  output logic                 s_wvalid,
  output data_t                s_wdata,
  output strb_t                s_wstrb,
  output logic                 s_wlast,
  input  logic                 s_wready,

  // Handshake events back to the grant control
  output logic                 aw_fire,
  output logic                 w_last_fire
);

  // AW path, ID extended with the manager index on top
  assign s_awvalid = grant_valid & m_awvalid[grant_idx];
  assign s_awid    = {grant_idx, m_awid[grant_idx]};
  assign s_awaddr  = m_awaddr[grant_idx];
  assign s_awlen   = m_awlen[grant_idx];
  assign s_awsize  = m_awsize[grant_idx];
  assign s_awburst = m_awburst[grant_idx];

  // W path
  assign s_wvalid = grant_valid & m_wvalid[grant_idx];
  assign s_wdata  = m_wdata[grant_idx];
  assign s_wstrb  = m_wstrb[grant_idx];
  assign s_wlast  = m_wlast[grant_idx];

  // Ready goes back to the granted manager only
  always_comb begin
    m_awready = '0;
    m_wready  = '0;
    if (grant_valid) begin
      m_awready[grant_idx] = s_awready;
      m_wready[grant_idx]  = s_wready;
    end
  end

  assign aw_fire     = s_awvalid & s_awready;
  assign w_last_fire = s_wvalid & s_wready & s_wlast;

endmodule

`default_nettype wire

/* hdl/wr_grant_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_grant_ctrl
  import arb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mgr_mask_t req,
  input  logic      aw_fire,
  input  logic      w_last_fire,
  output logic      grant_valid,
  output mgr_idx_t  grant_idx
);

  grant_state_t state;
  logic         aw_done;
  logic         w_done;
  logic         pick_valid;
  mgr_idx_t     pick_idx;
  logic         take;
  logic         aw_all;
  logic         w_all;

  // Only arbitrate between grants
  assign take = (state == GRANT_IDLE);

  rr_grant u_rr_grant (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .take      (take),
    .pick_valid(pick_valid),
    .pick_idx  (pick_idx)
  );

  // Include this cycle's pulses so release happens on the later event
  assign aw_all = aw_done | aw_fire;
  assign w_all  = w_done | w_last_fire;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= GRANT_IDLE;
      grant_idx <= '0;
      aw_done   <= 1'b0;
      w_done    <= 1'b0;
    end else begin
      case (state)
        GRANT_IDLE: begin
          if (pick_valid) begin
            grant_idx <= pick_idx;
            state     <= GRANT_BUSY;
          end
        end
        GRANT_BUSY: begin
          if (aw_all && w_all) begin
            state   <= GRANT_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end else begin
            aw_done <= aw_all;
            w_done  <= w_all;
          end
        end
        default: state <= GRANT_IDLE;
      endcase
    end
  end

  assign grant_valid = (state == GRANT_BUSY);

endmodule

`default_nettype wire

/* hdl/rr_grant.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_grant
  import arb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mgr_mask_t req,
  input  logic      take,
  output logic      pick_valid,
  output mgr_idx_t  pick_idx
);

  // Index of the manager that won last
  mgr_idx_t last_idx;

  // Scan from farthest to nearest so the nearest requester after
  // last_idx is the one left standing
  always_comb begin : search
    int cand;
    pick_valid = 1'b0;
    pick_idx   = last_idx;
    for (int i = NUM_M; i > 0; i--) begin
      cand = (int'(last_idx) + i) % NUM_M;
      if (req[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = mgr_idx_t'(cand);
      end
    end
  end

  // Start pointing at the last manager so manager 0 comes first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_idx <= mgr_idx_t'(NUM_M - 1);
    end else if (take && pick_valid) begin
      last_idx <= pick_idx;
    end
  end

endmodule

`default_nettype wire

/* hdl/arb_pkg.sv */
`default_nettype none

package arb_pkg;
  import axi_wr_pkg::*;

  // Manager count and derived index width
  localparam int NUM_M     = 3;
  localparam int MGR_IDX_W = $clog2(NUM_M);

  // Subordinate ID carries the manager index above the original ID
  localparam int S_ID_W = AXI_ID_W + MGR_IDX_W;

  typedef logic [MGR_IDX_W-1:0] mgr_idx_t;
  typedef logic [NUM_M-1:0]     mgr_mask_t;
  typedef logic [S_ID_W-1:0]    sid_t;

  typedef enum logic {
    GRANT_IDLE,
    GRANT_BUSY
  } grant_state_t;

endpackage

`default_nettype wire

/* hdl/axi_wr_pkg.sv */
`default_nettype none

package axi_wr_pkg;

  // Field widths of the AXI write channels
  localparam int AXI_ADDR_W = 20;
  localparam int AXI_DATA_W = 16;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 4;

  // Manager-side payload fields
  typedef logic [AXI_ADDR_W-1:0] addr_t;
  typedef logic [AXI_DATA_W-1:0] data_t;
  typedef logic [AXI_STRB_W-1:0] strb_t;
  typedef logic [AXI_ID_W-1:0]   id_t;

  // Burst control fields, fixed by the protocol
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;

  // Write response code
  typedef logic [1:0] resp_t;

endpackage

`default_nettype wire
